/* tinyCore.f */
coreTypes.sv
regFile.sv
insnDecode.sv
execUnit.sv
coreControl.sv
tinyCore.sv
tbClock.sv
tbChecker.sv
tinyCore_assert.sv
tb_tinyCore.sv

/* run.sh */
#!/bin/sh
# build with Verilator, then run and look for the pass line
verilator --binary --timing --assert -f tinyCore.f --top-module tb_tinyCore -o simTinyCore \
    && ./obj_dir/simTinyCore | tee /dev/stderr | grep -qx "All checks passed" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* tinyCore_stim.txt */
# I word-address instruction | D word-address data | E store-address store-data
# F fault-cycle(hex, counted from reset release) 0 ; all values hex
I 00 C1080F0F
I 01 C2000005
I 02 CD000020
I 03 2D120010
I 04 2D121010
I 05 2D122010
I 06 2D123010
I 07 2D124010
I 08 2D125010
I 09 2D126010
I 0A 2D127010
I 0B 2D128010
I 0C 2D129010
I 0D 2D12A010
I 0E 2D12B010
I 0F 2D12C010
I 10 2D12D010
I 11 2D12E010
I 12 2D12F010
I 13 2D21C010
I 14 6D12C100
I 15 AD12C100
I 16 AD12CFFF
I 17 CC000030
I 18 F5C00000
I 19 D5000031
I 1A C0000777
I 1B D0000034
I 1C CFF00002
I 1D D0000033
I 1E D0000033
I 1F DD000035
I 20 C700001E
I 21 C30FFFFC
I 22 C77FFFFF
I 23 08706000
I 24 09389000
I 25 0F9F4000
I 26 D0000036
I 27 CFFFFFFF
D 30 CAFEF00D
E 20 FFF80F1F
E 20 00000015
E 20 FFF80F1A
E 20 FFFFC088
E 20 FFF80F24
E 20 FFD84B5B
E 20 00000010
E 20 0000000F
E 20 0000000F
E 20 FFF80F1A
E 20 80F0F015
E 20 07FFC088
E 20 FFF80F1A
E 20 FF01E1F0
E 20 00000010
E 20 00000010
E 20 0007F106
E 20 FFF80E14
E 20 0007F1F6
E 20 0007F0F5
E 31 CAFEF00D
E 34 00000000
E 35 00000020
F 21C 0

/* tb_tinyCore.sv */
`default_nettype none

module tb_tinyCore;
    import coreTypes::*;

    localparam string stimFile   = "tinyCore_stim.txt";
    localparam int    memWords   = 64;
    localparam int    haltSettle = 40; // cycles watched after halt

    logic             clk, reset;
    busReq            insnReq, dataReq;
    logic             insnStb, dataStb, halt;
    logic             insnAck   = 1'b0;
    logic             dataAck   = 1'b0;
    logic             fault     = 1'b0;
    logic [31:0]      insnData  = '0;
    logic [31:0]      dataRdata = '0;
    logic [1:0]       insnWait  = '0;
    logic [1:0]       dataWait  = '0;
    logic [31:0]      lcgState  = 32'd56;
    logic [31:0]      imem [0:memWords-1];
    logic [31:0]      dmem [0:memWords-1];
    logic [31:0]      expAddr [0:63];
    logic [31:0]      expData [0:63];
    int               expCount, insnCount, faultCycle, limit, cycle;
    int               storeCount, checkErrors, errorCount;

    tbClock u_clock (.clk_o(clk), .reset_o(reset));

    tinyCore u_tinyCore (
        .clk, .reset, .insnReq_o(insnReq), .insnStb_o(insnStb), .insnAck_i(insnAck),
        .insnData_i(insnData), .dataReq_o(dataReq), .dataStb_o(dataStb),
        .dataAck_i(dataAck), .dataRdata_i(dataRdata), .fault_i(fault), .halt_o(halt)
    );

    tbChecker u_check (
        .clk, .reset, .insnReq_i(insnReq), .insnStb_i(insnStb), .insnAck_i(insnAck),
        .dataReq_i(dataReq), .dataStb_i(dataStb), .dataAck_i(dataAck),
        .fault_i(fault), .halt_i(halt), .expAddr_i(expAddr), .expData_i(expData),
        .expCount_i(expCount), .storeCount_o(storeCount), .errorCount_o(checkErrors)
    );

    function automatic logic [1:0] nextDelay();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[17:16]; // 0 to 3 wait cycles
    endfunction

    task automatic loadStim(output bit ok);
        int          fd;
        int          n;
        string       line;
        logic [7:0]  tag;
        logic [31:0] a, b;
        for (int i = 0; i < memWords; i++) begin
            imem[i] = 32'hCF000000 | i;      // spin on itself
            dmem[i] = 32'hA5A50000 | i;
        end
        expCount   = 0;
        insnCount  = 0;
        faultCycle = 0;
        ok         = 1'b0;
        fd = $fopen(stimFile, "r");
        if (fd == 0) begin
            $display("could not open the stimulus file %s", stimFile);
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%c %h %h", tag, a, b);
                    case (tag)
                        "I": begin
                            imem[a[5:0]] = b;
                            insnCount++;
                        end
                        "D": dmem[a[5:0]] = b;
                        "E": begin
                            expAddr[expCount] = a;
                            expData[expCount] = b;
                            expCount++;
                        end
                        "F": faultCycle = a;
                        default: ;
                    endcase
                end
            end
            $fclose(fd);
            limit = insnCount * 12 + 200;
            ok    = 1'b1;
        end
    endtask

    // memory models with random wait states
    always @(posedge clk) begin
        if (reset) begin
            insnAck  <= 1'b0;
            dataAck  <= 1'b0;
            insnWait <= 2'd0;
            dataWait <= 2'd0;
        end else begin
            insnAck <= 1'b0;
            dataAck <= 1'b0;
            if (insnStb && !insnAck) begin
                if (insnWait == 2'd0) begin
                    insnAck  <= 1'b1;
                    insnData <= imem[insnReq.addr[5:0]];
                    insnWait <= nextDelay();
                end else begin
                    insnWait <= insnWait - 2'd1;
                end
            end
            if (dataStb && !dataAck) begin
                if (dataWait == 2'd0) begin
                    dataAck  <= 1'b1;
                    dataWait <= nextDelay();
                    if (dataReq.we) dmem[dataReq.addr[5:0]] <= dataReq.wdata;
                    else dataRdata <= dmem[dataReq.addr[5:0]];
                end else begin
                    dataWait <= dataWait - 2'd1;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (reset) cycle <= 0;
        else cycle <= cycle + 1;
        fault <= !reset && cycle >= faultCycle; // held high once reached
    end

    always @(posedge clk) begin
        if (!reset && cycle >= limit) begin
            $display("timeout after %0d cycles without the core halting", cycle);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        bit stimOk;
        limit = 100000;
        loadStim(stimOk);
        if (!stimOk) begin
            $display("Checks failed");
            $finish;
        end else begin
            wait (!reset);
            while (!halt) @(posedge clk);
            repeat (haltSettle) @(posedge clk);
            errorCount = checkErrors;
            if (storeCount < expCount) begin
                $display("only %0d of %0d expected stores were seen", storeCount, expCount);
                errorCount++;
            end
            $display("stores seen %0d, expected %0d, errors %0d",
                     storeCount, expCount, errorCount);
            if (errorCount == 0) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* tinyCore_assert.sv */
`default_nettype none

module tinyCore_assert (
    input logic             clk,
    input logic             reset,
    input coreTypes::busReq insnReq_o,
    input logic             insnStb_o,
    input logic             insnAck_i,
    input coreTypes::busReq dataReq_o,
    input logic             dataStb_o,
    input logic             dataAck_i
);
    insnHeld: assert property (@(posedge clk) disable iff (reset)
        insnStb_o && !insnAck_i |=> insnStb_o && $stable(insnReq_o))
        else $error("instruction request changed before acknowledge");

    dataHeld: assert property (@(posedge clk) disable iff (reset)
        dataStb_o && !dataAck_i |=> dataStb_o && $stable(dataReq_o))
        else $error("data request changed before acknowledge");

    strobesIdleInReset: assert property (@(posedge clk) reset |-> !insnStb_o && !dataStb_o)
        else $error("bus strobe high during reset");

    insnDropAfterAck: assert property (@(posedge clk) disable iff (reset)
        insnStb_o && insnAck_i |=> !insnStb_o)
        else $error("instruction strobe still high after acknowledge");

    dataDropAfterAck: assert property (@(posedge clk) disable iff (reset)
        dataStb_o && dataAck_i |=> !dataStb_o)
        else $error("data strobe still high after acknowledge");

endmodule

bind coreControl tinyCore_assert u_assert (
    .clk(clk), .reset(reset),
    .insnReq_o(insnReq_o), .insnStb_o(insnStb_o), .insnAck_i(insnAck_i),
    .dataReq_o(dataReq_o), .dataStb_o(dataStb_o), .dataAck_i(dataAck_i)
);

`default_nettype wire

/* tbChecker.sv */
`default_nettype none

module tbChecker (
    input  logic             clk,
    input  logic             reset,
    input  coreTypes::busReq insnReq_i,
    input  logic             insnStb_i,
    input  logic             insnAck_i,
    input  coreTypes::busReq dataReq_i,
    input  logic             dataStb_i,
    input  logic             dataAck_i,
    input  logic             fault_i,
    input  logic             halt_i,
    input  logic [31:0]      expAddr_i [0:63],
    input  logic [31:0]      expData_i [0:63],
    input  int               expCount_i,
    output int               storeCount_o,
    output int               errorCount_o
);
    logic faultPrev;
    logic faultEver;
    int   haltFetches;

    task automatic compareValue(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %08h actual %08h", name, expected, actual);
            errorCount_o++;
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            storeCount_o = 0;
            errorCount_o = 0;
            faultPrev    = 1'b0;
            faultEver    = 1'b0;
            haltFetches  = 0;
        end else begin
            if (faultPrev && !halt_i) begin
                $display("halt output did not rise one cycle after the fault input");
                errorCount_o++;
            end
            if (halt_i && !faultEver) begin
                $display("halt output rose without a fault");
                errorCount_o++;
            end
            if (insnStb_i && insnReq_i.we) begin
                $display("instruction request to %08h asked for a write", insnReq_i.addr);
                errorCount_o++;
            end
            if (halt_i && insnStb_i && insnAck_i) begin
                haltFetches++; // one fetch may still finish
                if (haltFetches > 1) begin
                    $display("core kept fetching instructions after it halted");
                    errorCount_o++;
                end
            end
            if (dataStb_i && dataAck_i && dataReq_i.we) begin
                if (halt_i) begin
                    $display("a store to %08h completed after the core halted", dataReq_i.addr);
                    errorCount_o++;
                end else if (storeCount_o >= expCount_i) begin
                    $display("unexpected store of %08h to %08h", dataReq_i.wdata, dataReq_i.addr);
                    errorCount_o++;
                end else begin
                    compareValue($sformatf("store %0d address", storeCount_o),
                                 expAddr_i[storeCount_o], dataReq_i.addr);
                    compareValue($sformatf("store %0d data", storeCount_o),
                                 expData_i[storeCount_o], dataReq_i.wdata);
                end
                storeCount_o++;
            end
            faultEver = faultEver | fault_i;
            faultPrev = fault_i;
        end
    end

endmodule

`default_nettype wire

/* tbClock.sv */
`default_nettype none

module tbClock (
    output logic clk_o,
    output logic reset_o
);
    localparam int halfPeriod  = 10;
    localparam int resetCycles = 10;

    initial begin
        clk_o = 1'b0;
        forever #halfPeriod clk_o = ~clk_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (resetCycles) @(posedge clk_o);
        reset_o <= 1'b0; // released on an edge like other inputs
    end

endmodule

`default_nettype wire

/* tinyCore.sv */
`default_nettype none

module tinyCore (
    input  logic                            clk,
    input  logic                            reset,
    output coreTypes::busReq                insnReq_o,
    output logic                            insnStb_o,
    input  logic                            insnAck_i,
    input  logic [coreTypes::dataWidth-1:0] insnData_i,
    output coreTypes::busReq                dataReq_o,
    output logic                            dataStb_o,
    input  logic                            dataAck_i,
    input  logic [coreTypes::dataWidth-1:0] dataRdata_i,
    input  logic                            fault_i,
    output logic                            halt_o
);
    import coreTypes::*;

    decodedInsn           decoded;
    logic [dataWidth-1:0] insnWord, valX, valY, valZ;
    logic [dataWidth-1:0] operandA, operandB, operandC;
    logic [dataWidth-1:0] execResult, regWdata, pcNext;
    logic                 startExec, execDone, regWe;

    coreControl u_control (
        .clk, .reset, .insnReq_o, .insnStb_o, .insnAck_i, .insnData_i,
        .dataReq_o, .dataStb_o, .dataAck_i, .dataRdata_i, .fault_i, .halt_o,
        .insn_o(insnWord), .decoded_i(decoded), .valZ_i(valZ),
        .startExec_o(startExec), .execDone_i(execDone), .execResult_i(execResult),
        .regWe_o(regWe), .regWdata_o(regWdata), .pcNext_o(pcNext)
    );

    regFile u_regFile (
        .clk, .reset, .idxX_i(decoded.idxX), .idxY_i(decoded.idxY), .idxZ_i(decoded.idxZ),
        .we_i(regWe), .wdata_i(regWdata), .pcNext_i(pcNext),
        .valX_o(valX), .valY_o(valY), .valZ_o(valZ)
    );

    insnDecode u_decode (
        .insn_i(insnWord), .valX_i(valX), .valY_i(valY), .decoded_o(decoded),
        .operandA_o(operandA), .operandB_o(operandB), .operandC_o(operandC)
    );

    execUnit u_exec (
        .clk, .reset, .start_i(startExec), .op_i(decoded.opcode),
        .operandA_i(operandA), .operandB_i(operandB), .operandC_i(operandC),
        .done_o(execDone), .result_o(execResult)
    );

endmodule

`default_nettype wire

/* coreControl.sv */
`default_nettype none

module coreControl (
    input  logic                            clk,
    input  logic                            reset,
    output coreTypes::busReq                insnReq_o,
    output logic                            insnStb_o,
    input  logic                            insnAck_i,
    input  logic [coreTypes::dataWidth-1:0] insnData_i,
    output coreTypes::busReq                dataReq_o,
    output logic                            dataStb_o,
    input  logic                            dataAck_i,
    input  logic [coreTypes::dataWidth-1:0] dataRdata_i,
    input  logic                            fault_i,
    output logic                            halt_o,
    output logic [coreTypes::dataWidth-1:0] insn_o,
    input  coreTypes::decodedInsn           decoded_i,
    input  logic [coreTypes::dataWidth-1:0] valZ_i,
    output logic                            startExec_o,
    input  logic                            execDone_i,
    input  logic [coreTypes::dataWidth-1:0] execResult_i,
    output logic                            regWe_o,
    output logic [coreTypes::dataWidth-1:0] regWdata_o,
    output logic [coreTypes::dataWidth-1:0] pcNext_o
);
    import coreTypes::*;

    ctrlState             state;
    logic [dataWidth-1:0] pc;
    logic [dataWidth-1:0] pcNext;
    logic [dataWidth-1:0] insnWord;
    logic [dataWidth-1:0] result;
    logic [dataWidth-1:0] loadData;
    logic                 isMem;

    assign isMem = decoded_i.isLoad | decoded_i.isStore;

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= stFetch;
            pc     <= resetVector;
            pcNext <= resetVector + 1;
            halt_o <= 1'b0;
        end else begin
            halt_o <= halt_o | fault_i; // sticky until reset
            case (state)
                stFetch:      if (insnAck_i) state <= stFetchLatch;
                stFetchLatch: begin
                    pcNext <= pc + 1;
                    state  <= stIssue;
                end
                stIssue:      if (!halt_o) state <= stExec; // parked while halted
                stExec:       if (execDone_i) state <= stRoute;
                stRoute:      state <= isMem ? stMemory : stWrite;
                stMemory:     if (dataAck_i) state <= stWrite;
                stWrite: begin
                    pc    <= decoded_i.isBranch ? regWdata_o : pcNext;
                    state <= stFetch;
                end
                default:      state <= stFetch;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == stFetch && insnAck_i) insnWord <= insnData_i;
        if (state == stExec && execDone_i) result <= execResult_i;
        if (state == stMemory && dataAck_i) loadData <= dataRdata_i;
    end

    // instruction bus, read only
    assign insnStb_o       = state == stFetch && !reset;
    assign insnReq_o.addr  = pc;
    assign insnReq_o.wdata = '0;
    assign insnReq_o.we    = 1'b0;

    assign dataStb_o       = state == stMemory && !reset;
    assign dataReq_o.addr  = decoded_i.derefRhs ? valZ_i : result;
    assign dataReq_o.wdata = decoded_i.derefRhs ? result : valZ_i;
    assign dataReq_o.we    = decoded_i.isStore;

    assign insn_o      = insnWord;
    assign startExec_o = state == stIssue && !halt_o;
    assign regWe_o     = state == stWrite && !decoded_i.isStore;
    assign regWdata_o  = decoded_i.isLoad ? loadData : result;
    assign pcNext_o    = pcNext;

endmodule

`default_nettype wire

/* execUnit.sv */
`default_nettype none

module execUnit (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            start_i,
    input  coreTypes::aluOp                 op_i,
    input  logic [coreTypes::dataWidth-1:0] operandA_i,
    input  logic [coreTypes::dataWidth-1:0] operandB_i,
    input  logic [coreTypes::dataWidth-1:0] operandC_i,
    output logic                            done_o,
    output logic [coreTypes::dataWidth-1:0] result_o
);
    import coreTypes::*;

    aluOp                 opReg;
    logic [dataWidth-1:0] aReg, bReg, cReg;
    logic [dataWidth-1:0] opOut, cDelay, sum;
    logic                 tok1, tok2, tok3;

    // start token, one flop per stage
    always_ff @(posedge clk) begin
        if (reset) begin
            {tok1, tok2, tok3, done_o} <= '0;
        end else begin
            {tok1, tok2, tok3, done_o} <= {start_i, tok1, tok2, tok3};
        end
    end

    always_ff @(posedge clk) begin
        opReg  <= op_i; // stage 1
        aReg   <= operandA_i;
        bReg   <= operandB_i;
        cReg   <= operandC_i;
        cDelay <= cReg; // stage 2
        case (opReg)
            opOr:      opOut <= aReg | bReg;
            opAnd:     opOut <= aReg & bReg;
            opXor:     opOut <= aReg ^ bReg;
            opSra:     opOut <= $signed(aReg) >>> bReg;
            opAdd:     opOut <= aReg + bReg;
            opMul:     opOut <= aReg * bReg;
            opEq:      opOut <= {dataWidth{aReg == bReg}};
            opLt:      opOut <= {dataWidth{$signed(aReg) < $signed(bReg)}};
            opOrNot:   opOut <= aReg | ~bReg;
            opAndNot:  opOut <= aReg & ~bReg;
            opPack:    opOut <= {aReg[19:0], bReg[11:0]};
            opSrl:     opOut <= aReg >> bReg;
            opSub:     opOut <= aReg - bReg;
            opSll:     opOut <= aReg << bReg;
            opBitTest: opOut <= {dataWidth{|(aReg & (32'd1 << bReg))}};
            opGe:      opOut <= {dataWidth{$signed(aReg) >= $signed(bReg)}};
            default:   opOut <= '0;
        endcase
        sum      <= opOut + cDelay; // stage 3 addend
        result_o <= sum;            // stage 4
    end

endmodule

`default_nettype wire

/* insnDecode.sv */
`default_nettype none

module insnDecode (
    input  logic [coreTypes::dataWidth-1:0] insn_i,
    input  logic [coreTypes::dataWidth-1:0] valX_i,
    input  logic [coreTypes::dataWidth-1:0] valY_i,
    output coreTypes::decodedInsn           decoded_o,
    output logic [coreTypes::dataWidth-1:0] operandA_o,
    output logic [coreTypes::dataWidth-1:0] operandB_o,
    output logic [coreTypes::dataWidth-1:0] operandC_o
);
    import coreTypes::*;

    insnForm              form;
    logic [1:0]           deref;
    regIdx                idxZ;
    regIdx                idxX;
    logic [19:0]          low;
    logic [dataWidth-1:0] imm;

    assign form  = insnForm'(insn_i[31:30]);
    assign deref = insn_i[29:28];
    assign idxZ  = insn_i[27:24];
    assign idxX  = insn_i[23:20];
    assign low   = insn_i[19:0];

    always_comb begin
        decoded_o.form = form;
        decoded_o.idxZ = idxZ;
        decoded_o.idxX = idxX;
        if (form == formLongImm) begin
            imm              = {{12{low[19]}}, low};
            decoded_o.opcode = opAdd;
            decoded_o.idxY   = '0; // reads as zero
        end else begin
            imm              = {{20{low[11]}}, low[11:0]};
            decoded_o.opcode = aluOp'(low[15:12]);
            decoded_o.idxY   = low[19:16];
        end
        decoded_o.imm      = imm;
        decoded_o.isLoad   = &deref;
        decoded_o.isStore  = ^deref;
        decoded_o.derefRhs = ~deref[0];
        decoded_o.isBranch = (idxZ == 4'd15) && !(^deref);
    end

    // operand order per form
    always_comb begin
        case (form)
            formRegReg: {operandA_o, operandB_o, operandC_o} = {valX_i, valY_i, imm};
            formRegImm: {operandA_o, operandB_o, operandC_o} = {valX_i, imm, valY_i};
            formImmReg: {operandA_o, operandB_o, operandC_o} = {imm, valX_i, valY_i};
            default:    {operandA_o, operandB_o, operandC_o} = {{dataWidth{1'b0}}, valX_i, imm};
        endcase
    end

endmodule

`default_nettype wire

/* regFile.sv */
`default_nettype none

module regFile (
    input  logic                             clk,
    input  logic                             reset,
    input  coreTypes::regIdx                 idxX_i,
    input  coreTypes::regIdx                 idxY_i,
    input  coreTypes::regIdx                 idxZ_i,
    input  logic                             we_i,
    input  logic [coreTypes::dataWidth-1:0]  wdata_i,
    input  logic [coreTypes::dataWidth-1:0]  pcNext_i,
    output logic [coreTypes::dataWidth-1:0]  valX_o,
    output logic [coreTypes::dataWidth-1:0]  valY_o,
    output logic [coreTypes::dataWidth-1:0]  valZ_o
);
    import coreTypes::*;

    logic [dataWidth-1:0] regs [1:14];

    function automatic logic [dataWidth-1:0] readReg(input regIdx idx);
        if (idx == 4'd0) return '0;        // hardwired zero
        if (idx == 4'd15) return pcNext_i; // next instruction address
        return regs[idx];
    endfunction

    assign valX_o = readReg(idxX_i);
    assign valY_o = readReg(idxY_i);
    assign valZ_o = readReg(idxZ_i);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 1; k <= 14; k++) regs[k] <= '0;
        end else if (we_i && idxZ_i != 4'd0 && idxZ_i != 4'd15) begin
            regs[idxZ_i] <= wdata_i; // r15 goes to the pc instead
        end
    end

endmodule

`default_nettype wire

/* coreTypes.sv */
`default_nettype none

package coreTypes;

    localparam int dataWidth = 32;
    localparam logic [dataWidth-1:0] resetVector = '0; // first fetch address

    typedef logic [3:0] regIdx;

    typedef enum logic [3:0] {
        opOr      = 4'h0,
        opAnd     = 4'h1,
        opXor     = 4'h2,
        opSra     = 4'h3,
        opAdd     = 4'h4,
        opMul     = 4'h5,
        opEq      = 4'h6,
        opLt      = 4'h7,
        opOrNot   = 4'h8,
        opAndNot  = 4'h9,
        opPack    = 4'ha, // a << 12 joined with low 12 bits of b
        opSrl     = 4'hb,
        opSub     = 4'hc,
        opSll     = 4'hd,
        opBitTest = 4'he,
        opGe      = 4'hf
    } aluOp;

    typedef enum logic [1:0] {
        formRegReg  = 2'b00,
        formRegImm  = 2'b01,
        formImmReg  = 2'b10,
        formLongImm = 2'b11  // 20-bit immediate, opcode fixed to add
    } insnForm;

    typedef enum logic [2:0] {
        stFetch, stFetchLatch, stIssue, stExec, stRoute, stMemory, stWrite
    } ctrlState;

    typedef struct packed {
        logic [dataWidth-1:0] addr;
        logic [dataWidth-1:0] wdata;
        logic                 we;
    } busReq;

    typedef struct packed {
        insnForm              form;
        aluOp                 opcode;
        regIdx                idxZ;
        regIdx                idxX;
        regIdx                idxY;
        logic [dataWidth-1:0] imm;
        logic                 isLoad;
        logic                 isStore;
        logic                 derefRhs; // register z holds the address
        logic                 isBranch;
    } decodedInsn;

endpackage

`default_nettype wire
